// File: wb_cases.txt
# three lines per case, all hex
# stim: valid_in is_reg is_seg is_mem wb size ovr op_bit br_valid br_taken br_correct br_fip ie ie_type idt_orig idt_serving interrupt wbaq_full latched_eip
# steer: reg_ld seg_ld mem_ld mem_addr memsize reg_addr res1 mem_data
# branch: fip_e fip_o new_eip br_valid resteer valid_out stall ie_val ie_type final_wb halts hist1 hist2
1 3 4 8 f 2 0 00 0 0 1 00001020 0 0 0 0 0 0 00000100
3 4 1 00004004 2 8d1 0000123400400100 4444000044440004
00001020 00001030 00005000 0 0 1 0 0 0 0 0 00000100 00000000
1 0 1 6 7 1 4 20 0 0 1 00001020 0 0 0 0 0 0 00000200
0 1 1 00002002 2 8d1 0000000000001234 2222000022220002
00001020 00001030 00005000 0 0 1 0 0 0 0 0 00000200 00000100
1 0 0 1 1 1 0 24 1 1 1 00001040 0 0 0 0 0 0 00000300
0 0 1 00001001 3 8d1 0000000000001234 0000123400400100
00001040 00001050 00400100 1 0 1 0 1 1 0 0 00000300 00000200
1 1 0 2 3 0 0 00 0 0 1 00001020 0 0 0 0 0 1 00000400
0 0 0 00000000 0 8d1 0000123400400100 0000000000000000
00001020 00001030 00005000 0 0 0 1 0 0 0 0 00000300 00000200
1 1 0 2 3 0 0 0c 0 0 1 00001020 0 0 1 0 0 1 00000500
1 0 1 00002002 0 8d1 0000123400400100 2222000022220002
00001020 00001030 00005000 0 0 1 1 0 0 1 0 00000500 00000300
1 0 0 0 0 0 0 00 1 1 0 00003010 0 0 0 0 0 0 00000600
0 0 0 00000000 0 8d1 0000123400400100 0000000000000000
00003020 00003010 00003010 1 1 1 0 1 2 0 0 00000600 00000500
1 0 0 0 0 0 0 00 1 1 1 00010000 0 0 0 0 1 0 00000700
0 0 0 00000000 0 8d1 0000123400400100 0000000000000000
00010000 00010010 00010000 1 0 1 0 1 b 0 0 00000700 00000600
1 0 0 0 0 0 0 09 0 0 1 00001020 1 4 0 0 0 0 00000800
0 0 0 00000000 0 8d1 0000123400400100 0000000000000000
00001020 00001030 00005000 0 0 0 0 1 4 0 0 00000700 00000600
1 0 0 0 0 0 0 09 0 0 1 00001020 0 0 0 0 0 0 00000900
0 0 0 00000000 0 8d1 0000123400400100 0000000000000000
00001020 00001030 00005000 0 0 1 0 0 0 0 1 00000900 00000700
0 0 0 0 0 0 0 09 0 0 1 00001020 1 5 0 0 0 0 00000a00
0 0 0 00000000 0 8d1 0000123400400100 0000000000000000
00001020 00001030 00005000 0 0 0 0 0 0 0 1 00000900 00000700
1 0 0 0 0 0 0 00 0 0 1 00001020 1 6 0 1 0 0 00000b00
0 0 0 00000000 0 8d1 0000123400400100 0000000000000000
00001020 00001030 00005000 0 0 0 0 0 0 0 1 00000900 00000700

// File: compile.f
wb_types_pkg.sv
wb_ctrl_pkg.sv
fip_tlb_check.sv
wb_dest_steer.sv
branch_resteer.sv
wb_exception_merge.sv
wb_history_regs.sv
writeback_top.sv
writeback_assertions.sv
tb_writeback.sv

// File: tb_writeback.sv
`timescale 1ns/1ns

module tb_writeback;
    import wb_types_pkg::*;
    import wb_ctrl_pkg::*;

    localparam int clk_period = 100;
    localparam int max_cases = 32;

    logic clk;
    logic rst;
    logic valid_in;
    data_t slot_val1, slot_val2, slot_val3, slot_val4;
    addr_t slot_dest1, slot_dest2, slot_dest3, slot_dest4;
    slot_mask_t is_reg, is_seg, is_mem, wb;
    size_t size;
    logic [3:0] mem_size_ovr;
    logic br_valid_in, br_taken, br_correct;
    addr_t br_fip, br_fip_p1, eip, latched_eip;
    sel_t cs;
    logic [19:0] cs_lim;
    p_op_t p_op;
    logic [tlb_vec_w-1:0] vp, pf;
    logic ie, idt_orig, idt_serving, interrupt, wbaq_full;
    ie_type_t ie_type;

    data_t res1, res2, res3, res4, mem_data;
    size_t ressize, memsize;
    logic [11:0] reg_addr, seg_addr;
    slot_mask_t reg_ld, seg_ld;
    logic mem_ld, br_valid, is_resteer, valid_out, stall;
    logic final_ie_val, final_wb, is_iretd, halts;
    addr_t mem_addr, new_fip_e, new_fip_o, new_eip, eip_hist1, eip_hist2;
    ie_type_t final_ie_type;

    // stimulus, steering and branch/history columns of each case
    logic [63:0] stim_f [max_cases][19];
    logic [63:0] steer_f [max_cases][8];
    logic [63:0] br_f [max_cases][13];
    int n_cases;
    int value_errs;
    int other_errs;
    int fd;
    bit loaded;

    writeback_top dut (.*);

    bind writeback_top writeback_assertions u_asrt (
        .clk(clk), .rst(rst), .valid_out(valid_out), .stall(stall),
        .idt_orig(idt_orig), .reg_ld(reg_ld), .seg_ld(seg_ld),
        .mem_ld(mem_ld), .halts(halts)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic compare(input string name, input logic [63:0] act,
                           input logic [63:0] exp);
        assert (act === exp) else begin
            value_errs++;
            $display("error: time %0t, %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    task automatic next_data_line(output string line, output bit ok);
        int code;
        ok = 1'b0;
        line = "";
        while (!ok && !$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line[0] != "#") ok = 1'b1;  // skip comments
        end
    endtask

    task automatic load_cases();
        string la, lb, lc;
        bit oka, okb, okc;
        int na, nb, nc;
        int i;
        fd = $fopen("wb_cases.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("could not open the case file wb_cases.txt");
        end else begin
            while (n_cases < max_cases) begin
                i = n_cases;
                next_data_line(la, oka);
                if (!oka) break;
                next_data_line(lb, okb);
                next_data_line(lc, okc);
                if (!okb || !okc) begin
                    other_errs++;
                    $display("case %0d in the case file is incomplete", i);
                    break;
                end
                na = $sscanf(la, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    stim_f[i][0], stim_f[i][1], stim_f[i][2], stim_f[i][3],
                    stim_f[i][4], stim_f[i][5], stim_f[i][6], stim_f[i][7],
                    stim_f[i][8], stim_f[i][9], stim_f[i][10], stim_f[i][11],
                    stim_f[i][12], stim_f[i][13], stim_f[i][14], stim_f[i][15],
                    stim_f[i][16], stim_f[i][17], stim_f[i][18]);
                nb = $sscanf(lb, "%h %h %h %h %h %h %h %h",
                    steer_f[i][0], steer_f[i][1], steer_f[i][2], steer_f[i][3],
                    steer_f[i][4], steer_f[i][5], steer_f[i][6], steer_f[i][7]);
                nc = $sscanf(lc, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                    br_f[i][0], br_f[i][1], br_f[i][2], br_f[i][3], br_f[i][4],
                    br_f[i][5], br_f[i][6], br_f[i][7], br_f[i][8], br_f[i][9],
                    br_f[i][10], br_f[i][11], br_f[i][12]);
                if (na != 19 || nb != 8 || nc != 13) begin
                    other_errs++;
                    $display("case %0d in the case file has a wrong number of fields", i);
                    break;
                end
                n_cases++;
            end
            $fclose(fd);
        end
        if (n_cases == 0) begin
            other_errs++;
            $display("no cases were read from the case file");
        end
    endtask

    task automatic init_inputs();
        rst = 1'b1;
        valid_in = 1'b0;
        slot_val1 = 64'h0000_1234_0040_0100;  // selector 1234, far target 00400100
        slot_val2 = 64'h2222_0000_2222_0002;
        slot_val3 = 64'h3333_0000_3333_0003;
        slot_val4 = 64'h4444_0000_4444_0004;
        slot_dest1 = 32'h0000_1001;
        slot_dest2 = 32'h0000_2002;
        slot_dest3 = 32'h0000_3003;
        slot_dest4 = 32'h0000_4004;
        is_reg = '0;
        is_seg = '0;
        is_mem = '0;
        wb = '0;
        size = '0;
        mem_size_ovr = '0;
        br_valid_in = 1'b0;
        br_taken = 1'b0;
        br_correct = 1'b1;
        br_fip = '0;
        br_fip_p1 = 32'h10;
        eip = 32'h0000_5000;
        cs = 16'h0000;
        cs_lim = 20'h0ffff;
        p_op = '0;
        vp = '0;
        pf = '0;
        vp[19:0] = 20'h00001;  // page 1, valid
        pf[19:0] = 20'h00011;
        vp[39:20] = 20'h00002;  // page 2, not valid
        pf[39:20] = 20'h00020;
        ie = 1'b0;
        ie_type = '0;
        idt_orig = 1'b0;
        idt_serving = 1'b0;
        interrupt = 1'b0;
        wbaq_full = 1'b0;
        latched_eip = '0;
    endtask

    task automatic apply_case(input int i);
        valid_in <= stim_f[i][0][0];
        is_reg <= slot_mask_t'(stim_f[i][1]);
        is_seg <= slot_mask_t'(stim_f[i][2]);
        is_mem <= slot_mask_t'(stim_f[i][3]);
        wb <= slot_mask_t'(stim_f[i][4]);
        size <= size_t'(stim_f[i][5]);
        mem_size_ovr <= stim_f[i][6][3:0];
        p_op <= p_op_t'(1) << stim_f[i][7];  // column holds the op bit index
        br_valid_in <= stim_f[i][8][0];
        br_taken <= stim_f[i][9][0];
        br_correct <= stim_f[i][10][0];
        br_fip <= addr_t'(stim_f[i][11]);
        br_fip_p1 <= addr_t'(stim_f[i][11]) + 32'h10;
        ie <= stim_f[i][12][0];
        ie_type <= ie_type_t'(stim_f[i][13]);
        idt_orig <= stim_f[i][14][0];
        idt_serving <= stim_f[i][15][0];
        interrupt <= stim_f[i][16][0];
        wbaq_full <= stim_f[i][17][0];
        latched_eip <= addr_t'(stim_f[i][18]);
    endtask

    task automatic check_comb(input int i);
        compare("reg_ld", reg_ld, steer_f[i][0]);
        compare("seg_ld", seg_ld, steer_f[i][1]);
        compare("mem_ld", mem_ld, steer_f[i][2]);
        compare("mem_addr", mem_addr, steer_f[i][3]);
        compare("memsize", memsize, steer_f[i][4]);
        compare("reg_addr", reg_addr, steer_f[i][5]);
        compare("seg_addr", seg_addr, steer_f[i][5]);
        compare("res1", res1, steer_f[i][6]);
        compare("res2", res2, slot_val2);  // other slots pass through
        compare("res3", res3, slot_val3);
        compare("res4", res4, slot_val4);
        compare("ressize", ressize, stim_f[i][5]);
        compare("is_iretd", is_iretd, stim_f[i][7] == op_iretd);
        compare("mem_data", mem_data, steer_f[i][7]);
        compare("new_fip_e", new_fip_e, br_f[i][0]);
        compare("new_fip_o", new_fip_o, br_f[i][1]);
        compare("new_eip", new_eip, br_f[i][2]);
        compare("br_valid", br_valid, br_f[i][3]);
        compare("is_resteer", is_resteer, br_f[i][4]);
        compare("valid_out", valid_out, br_f[i][5]);
        compare("stall", stall, br_f[i][6]);
        compare("final_ie_val", final_ie_val, br_f[i][7]);
        compare("final_ie_type", final_ie_type, br_f[i][8]);
        compare("final_wb", final_wb, br_f[i][9]);
    endtask

    task automatic check_regs(input int i);
        compare("halts", halts, br_f[i][10]);
        compare("eip_hist1", eip_hist1, br_f[i][11]);
        compare("eip_hist2", eip_hist2, br_f[i][12]);
    endtask

    // watchdog
    initial begin
        wait (loaded);
        #((n_cases + 20) * clk_period);
        $display("timeout: the run did not end within %0d clock periods", n_cases + 20);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        value_errs = 0;
        other_errs = 0;
        n_cases = 0;
        loaded = 1'b0;
        init_inputs();
        load_cases();
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < n_cases; i++) begin
            @(posedge clk);
            apply_case(i);
            if (i > 0) begin
                #1;
                check_regs(i - 1);
            end
            @(negedge clk);
            check_comb(i);
        end
        @(posedge clk);
        valid_in <= 1'b0;
        p_op <= p_op_t'(1) << op_iretd;  // iretd flag follows the micro-op
        if (n_cases > 0) begin
            #1;
            check_regs(n_cases - 1);
        end
        @(negedge clk);
        compare("is_iretd", is_iretd, 64'h1);
        // reset clears the sticky halt and the history
        @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        #1;
        compare("halts", halts, 64'h0);
        compare("eip_hist1", eip_hist1, 64'h0);
        compare("eip_hist2", eip_hist2, 64'h0);
        other_errs += dut.u_asrt.fails;
        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: writeback_assertions.sv
`timescale 1ns/1ns

module writeback_assertions (
    input logic                     clk,
    input logic                     rst,
    input logic                     valid_out,
    input logic                     stall,
    input logic                     idt_orig,
    input wb_types_pkg::slot_mask_t reg_ld,
    input wb_types_pkg::slot_mask_t seg_ld,
    input logic                     mem_ld,
    input logic                     halts
);

    int fails;

    // no writes without a retiring instruction
    a_ld_idle: assert property (@(posedge clk) disable iff (rst)
        !valid_out |-> (reg_ld == '0 && seg_ld == '0 && !mem_ld))
        else begin
            fails++;
            $error("load enable high while valid_out is low");
        end

    a_stall_no_store: assert property (@(posedge clk) disable iff (rst)
        (stall && !idt_orig) |-> !mem_ld)  // idt service may still store
        else begin
            fails++;
            $error("memory load issued during stall");
        end

    a_halt_sticky: assert property (@(posedge clk) disable iff (rst)
        halts |=> (halts || rst))
        else begin
            fails++;
            $error("halt flag dropped without reset");
        end

endmodule

// File: writeback_top.sv
`timescale 1ns/1ns

module writeback_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              valid_in,
    input  wb_types_pkg::data_t               slot_val1,
    input  wb_types_pkg::data_t               slot_val2,
    input  wb_types_pkg::data_t               slot_val3,
    input  wb_types_pkg::data_t               slot_val4,
    input  wb_types_pkg::addr_t               slot_dest1,
    input  wb_types_pkg::addr_t               slot_dest2,
    input  wb_types_pkg::addr_t               slot_dest3,
    input  wb_types_pkg::addr_t               slot_dest4,
    input  wb_types_pkg::slot_mask_t          is_reg,
    input  wb_types_pkg::slot_mask_t          is_seg,
    input  wb_types_pkg::slot_mask_t          is_mem,
    input  wb_types_pkg::slot_mask_t          wb,
    input  wb_types_pkg::size_t               size,
    input  logic [3:0]                        mem_size_ovr,
    input  logic                              br_valid_in,
    input  logic                              br_taken,
    input  logic                              br_correct,
    input  wb_types_pkg::addr_t               br_fip,
    input  wb_types_pkg::addr_t               br_fip_p1,
    input  wb_types_pkg::addr_t               eip,
    input  wb_types_pkg::sel_t                cs,
    input  logic [19:0]                       cs_lim,
    input  wb_ctrl_pkg::p_op_t                p_op,
    input  logic [wb_ctrl_pkg::tlb_vec_w-1:0] vp,
    input  logic [wb_ctrl_pkg::tlb_vec_w-1:0] pf,
    input  logic                              ie,
    input  wb_types_pkg::ie_type_t            ie_type,
    input  logic                              idt_orig,
    input  logic                              idt_serving,
    input  logic                              interrupt,
    input  logic                              wbaq_full,
    input  wb_types_pkg::addr_t               latched_eip,
    output wb_types_pkg::data_t               res1,
    output wb_types_pkg::data_t               res2,
    output wb_types_pkg::data_t               res3,
    output wb_types_pkg::data_t               res4,
    output wb_types_pkg::size_t               ressize,
    output logic [11:0]                       reg_addr,
    output logic [11:0]                       seg_addr,
    output wb_types_pkg::slot_mask_t          reg_ld,
    output wb_types_pkg::slot_mask_t          seg_ld,
    output logic                              mem_ld,
    output wb_types_pkg::data_t               mem_data,
    output wb_types_pkg::addr_t               mem_addr,
    output wb_types_pkg::size_t               memsize,
    output wb_types_pkg::addr_t               new_fip_e,
    output wb_types_pkg::addr_t               new_fip_o,
    output wb_types_pkg::addr_t               new_eip,
    output logic                              br_valid,
    output logic                              is_resteer,
    output logic                              valid_out,
    output logic                              stall,
    output logic                              final_ie_val,
    output wb_types_pkg::ie_type_t            final_ie_type,
    output logic                              final_wb,
    output logic                              is_iretd,
    output logic                              halts,
    output wb_types_pkg::addr_t               eip_hist1,
    output wb_types_pkg::addr_t               eip_hist2
);
    import wb_ctrl_pkg::*;

    logic mem_pending;
    logic ld_eip_cs;
    logic seg_lim_exc;
    logic tlb_miss_exc;

    assign is_iretd = p_op[op_iretd];

    wb_dest_steer u_steer (
        .slot_val1(slot_val1), .slot_val2(slot_val2),
        .slot_val3(slot_val3), .slot_val4(slot_val4),
        .slot_dest1(slot_dest1), .slot_dest2(slot_dest2),
        .slot_dest3(slot_dest3), .slot_dest4(slot_dest4),
        .is_reg(is_reg), .is_seg(is_seg), .is_mem(is_mem), .wb(wb),
        .size(size), .mem_size_ovr(mem_size_ovr),
        .ld_eip_cs(ld_eip_cs), .valid_out(valid_out),
        .res1(res1), .res2(res2), .res3(res3), .res4(res4), .ressize(ressize),
        .reg_addr(reg_addr), .seg_addr(seg_addr), .reg_ld(reg_ld), .seg_ld(seg_ld),
        .mem_ld(mem_ld), .mem_data(mem_data), .mem_addr(mem_addr),
        .memsize(memsize), .mem_pending(mem_pending)
    );

    branch_resteer u_branch (
        .valid_in(valid_in), .valid_out(valid_out),
        .br_valid_in(br_valid_in), .br_taken(br_taken), .br_correct(br_correct),
        .br_fip(br_fip), .br_fip_p1(br_fip_p1), .eip(eip),
        .target(slot_val1[31:0]),  // far target from slot 1
        .cs(cs), .cs_lim(cs_lim), .p_op(p_op), .vp(vp), .pf(pf),
        .new_fip_e(new_fip_e), .new_fip_o(new_fip_o), .new_eip(new_eip),
        .br_valid(br_valid), .is_resteer(is_resteer), .ld_eip_cs(ld_eip_cs),
        .seg_lim_exc(seg_lim_exc), .tlb_miss_exc(tlb_miss_exc)
    );

    wb_exception_merge u_merge (
        .valid_in(valid_in), .ie(ie), .ie_type(ie_type),
        .idt_orig(idt_orig), .idt_serving(idt_serving), .interrupt(interrupt),
        .wbaq_full(wbaq_full), .mem_pending(mem_pending),
        .seg_lim_exc(seg_lim_exc), .tlb_miss_exc(tlb_miss_exc), .p_op(p_op),
        .valid_out(valid_out), .stall(stall), .final_ie_val(final_ie_val),
        .final_ie_type(final_ie_type), .final_wb(final_wb)
    );

    wb_history_regs u_hist (
        .clk(clk), .rst(rst), .valid_out(valid_out),
        .halt_op(p_op[op_halt]), .latched_eip(latched_eip),
        .halts(halts), .eip_hist1(eip_hist1), .eip_hist2(eip_hist2)
    );

endmodule

// File: wb_history_regs.sv
`timescale 1ns/1ns

module wb_history_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                valid_out,
    input  logic                halt_op,
    input  wb_types_pkg::addr_t latched_eip,
    output logic                halts,
    output wb_types_pkg::addr_t eip_hist1,
    output wb_types_pkg::addr_t eip_hist2
);

    always_ff @(posedge clk) begin
        if (rst) begin
            halts <= 1'b0;
            eip_hist1 <= '0;
            eip_hist2 <= '0;
        end else begin
            if (valid_out && halt_op) begin
                halts <= 1'b1;  // sticky until rst
            end
            if (valid_out) begin
                eip_hist1 <= latched_eip;
                eip_hist2 <= eip_hist1;
            end
        end
    end

endmodule

// File: wb_exception_merge.sv
`timescale 1ns/1ns

module wb_exception_merge (
    input  logic                   valid_in,
    input  logic                   ie,
    input  wb_types_pkg::ie_type_t ie_type,
    input  logic                   idt_orig,
    input  logic                   idt_serving,
    input  logic                   interrupt,
    input  logic                   wbaq_full,
    input  logic                   mem_pending,
    input  logic                   seg_lim_exc,
    input  logic                   tlb_miss_exc,
    input  wb_ctrl_pkg::p_op_t     p_op,
    output logic                   valid_out,
    output logic                   stall,
    output logic                   final_ie_val,
    output wb_types_pkg::ie_type_t final_ie_type,
    output logic                   final_wb
);
    import wb_types_pkg::*;
    import wb_ctrl_pkg::*;

    logic ie_live;
    ie_type_t type_in;

    assign stall = wbaq_full & valid_in & mem_pending;

    // IDT service instructions get through a stall or exception
    assign valid_out = valid_in & (idt_orig | (~stall & ~ie));

    assign ie_live = ie & valid_in & ~idt_serving;
    assign final_ie_val = interrupt | seg_lim_exc | tlb_miss_exc | ie_live;

    assign type_in = ie_type & {$bits(ie_type_t){valid_in & ~idt_serving}};

    always_comb begin
        final_ie_type = type_in;
        final_ie_type[ie_seg_lim] = type_in[ie_seg_lim] | seg_lim_exc;
        final_ie_type[ie_tlb_miss] = type_in[ie_tlb_miss] | tlb_miss_exc;
        final_ie_type[ie_intr] = interrupt;  // incoming bit 3 dropped
    end

    // jmp or far ret issued by the IDT sequence
    assign final_wb = valid_in & idt_orig & (p_op[op_jmp] | p_op[op_ret_far]);

endmodule

// File: branch_resteer.sv
`timescale 1ns/1ns

module branch_resteer (
    input  logic                              valid_in,
    input  logic                              valid_out,
    input  logic                              br_valid_in,
    input  logic                              br_taken,
    input  logic                              br_correct,
    input  wb_types_pkg::addr_t               br_fip,
    input  wb_types_pkg::addr_t               br_fip_p1,
    input  wb_types_pkg::addr_t               eip,
    input  wb_types_pkg::addr_t               target,
    input  wb_types_pkg::sel_t                cs,
    input  logic [19:0]                       cs_lim,
    input  wb_ctrl_pkg::p_op_t                p_op,
    input  logic [wb_ctrl_pkg::tlb_vec_w-1:0] vp,
    input  logic [wb_ctrl_pkg::tlb_vec_w-1:0] pf,
    output wb_types_pkg::addr_t               new_fip_e,
    output wb_types_pkg::addr_t               new_fip_o,
    output wb_types_pkg::addr_t               new_eip,
    output logic                              br_valid,
    output logic                              is_resteer,
    output logic                              ld_eip_cs,
    output logic                              seg_lim_exc,
    output logic                              tlb_miss_exc
);
    import wb_types_pkg::*;
    import wb_ctrl_pkg::*;

    addr_t line_cur;
    addr_t line_next;
    addr_t line_end;
    addr_t cs_max;
    logic tlb_hit;
    logic check_en;
    logic past_limit;

    fip_tlb_check u_tlb (
        .vp(vp),
        .pf(pf),
        .fip(line_end),
        .tlb_hit(tlb_hit)
    );

    assign ld_eip_cs = p_op[op_ret_far] | p_op[op_ld_cs] | p_op[op_far_a];

    // 16-byte fetch lines
    assign line_cur = {br_fip[31:4], 4'h0};
    assign line_next = {br_fip_p1[31:4], 4'h0};
    assign new_fip_e = br_fip[4] ? line_next : line_cur;  // bit 4 picks odd line
    assign new_fip_o = br_fip[4] ? line_cur : line_next;

    always_comb begin
        if (!br_taken) begin
            new_eip = eip;
        end else if (ld_eip_cs) begin
            new_eip = target;
        end else begin
            new_eip = br_fip;
        end
    end

    assign br_valid = br_valid_in & valid_out;
    assign is_resteer = valid_in & br_valid & ~br_correct;  // mispredict

    // last byte of the target line against CS base + limit
    assign line_end = {br_fip[31:4], 4'hf};
    assign cs_max = {cs, 16'h0000} + addr_t'(cs_lim);
    assign past_limit = line_end >= cs_max;

    assign check_en = valid_in & br_valid & br_taken;
    assign seg_lim_exc = check_en & (past_limit | tlb_hit);  // hit term counts as well
    assign tlb_miss_exc = check_en & ~tlb_hit;

endmodule

// File: wb_dest_steer.sv
`timescale 1ns/1ns

module wb_dest_steer (
    input  wb_types_pkg::data_t      slot_val1,
    input  wb_types_pkg::data_t      slot_val2,
    input  wb_types_pkg::data_t      slot_val3,
    input  wb_types_pkg::data_t      slot_val4,
    input  wb_types_pkg::addr_t      slot_dest1,
    input  wb_types_pkg::addr_t      slot_dest2,
    input  wb_types_pkg::addr_t      slot_dest3,
    input  wb_types_pkg::addr_t      slot_dest4,
    input  wb_types_pkg::slot_mask_t is_reg,
    input  wb_types_pkg::slot_mask_t is_seg,
    input  wb_types_pkg::slot_mask_t is_mem,
    input  wb_types_pkg::slot_mask_t wb,
    input  wb_types_pkg::size_t      size,
    input  logic [3:0]               mem_size_ovr,
    input  logic                     ld_eip_cs,
    input  logic                     valid_out,
    output wb_types_pkg::data_t      res1,
    output wb_types_pkg::data_t      res2,
    output wb_types_pkg::data_t      res3,
    output wb_types_pkg::data_t      res4,
    output wb_types_pkg::size_t      ressize,
    output logic [11:0]              reg_addr,
    output logic [11:0]              seg_addr,
    output wb_types_pkg::slot_mask_t reg_ld,
    output wb_types_pkg::slot_mask_t seg_ld,
    output logic                     mem_ld,
    output wb_types_pkg::data_t      mem_data,
    output wb_types_pkg::addr_t      mem_addr,
    output wb_types_pkg::size_t      memsize,
    output logic                     mem_pending
);
    import wb_types_pkg::*;

    slot_mask_t mem_sel;
    logic [slots*dest_idx_w-1:0] dest_idx;

    assign reg_ld = is_reg & wb & {slots{valid_out}};
    assign seg_ld = is_seg & wb & {slots{valid_out}};
    assign mem_sel = is_mem & wb & {slots{valid_out}};
    assign mem_ld = |mem_sel;
    assign mem_pending = |(is_mem & wb);  // intent only, no valid

    // slot 1 in the low bits
    assign dest_idx = {slot_dest4[dest_idx_w-1:0], slot_dest3[dest_idx_w-1:0],
                       slot_dest2[dest_idx_w-1:0], slot_dest1[dest_idx_w-1:0]};
    assign reg_addr = dest_idx;
    assign seg_addr = dest_idx;

    assign res1 = ld_eip_cs ? data_t'(slot_val1[47:32]) : slot_val1;  // far: selector
    assign res2 = slot_val2;
    assign res3 = slot_val3;
    assign res4 = slot_val4;
    assign ressize = size;

    // lowest slot with a store wins
    always_comb begin
        if (mem_sel[0]) begin
            mem_data = slot_val1;
            mem_addr = slot_dest1;
        end else if (mem_sel[1]) begin
            mem_data = slot_val2;
            mem_addr = slot_dest2;
        end else if (mem_sel[2]) begin
            mem_data = slot_val3;
            mem_addr = slot_dest3;
        end else if (mem_sel[3]) begin
            mem_data = slot_val4;
            mem_addr = slot_dest4;
        end else begin
            mem_data = '0;
            mem_addr = '0;
        end
    end

    always_comb begin
        memsize = size;
        if (|mem_size_ovr) begin
            for (int i = 3; i >= 0; i--) begin
                if (mem_size_ovr[i]) memsize = size_t'(i);  // index of the one-hot bit
            end
        end else if (ld_eip_cs) begin
            memsize = size_quad;
        end
    end

endmodule

// File: fip_tlb_check.sv
`timescale 1ns/1ns

module fip_tlb_check (
    input  logic [wb_ctrl_pkg::tlb_vec_w-1:0] vp,
    input  logic [wb_ctrl_pkg::tlb_vec_w-1:0] pf,
    input  wb_types_pkg::addr_t               fip,
    output logic                              tlb_hit
);
    import wb_types_pkg::*;
    import wb_ctrl_pkg::*;

    page_t fip_page;

    assign fip_page = fip[$bits(addr_t)-1 -: $bits(page_t)];

    // any valid entry with a matching virtual page
    always_comb begin
        page_t vp_e;
        page_t pf_e;

        tlb_hit = 1'b0;
        for (int i = 0; i < tlb_entries; i++) begin
            vp_e = vp[i*$bits(page_t) +: $bits(page_t)];
            pf_e = pf[i*$bits(page_t) +: $bits(page_t)];
            if (vp_e == fip_page && pf_e[0]) begin  // pf bit 0 is valid
                tlb_hit = 1'b1;
            end
        end
    end

endmodule

// File: wb_ctrl_pkg.sv
package wb_ctrl_pkg;

    localparam int p_op_w = 37;

    // micro-op vector, one bit per op class
    typedef logic [p_op_w-1:0] p_op_t;

    localparam int op_halt = 9;
    localparam int op_iretd = 10;
    localparam int op_jmp = 12;
    localparam int op_far_a = 32;    // far transfer loading EIP and CS
    localparam int op_ld_cs = 35;
    localparam int op_ret_far = 36;

    // fetch translation table
    localparam int tlb_entries = 8;
    localparam int tlb_vec_w = tlb_entries * $bits(wb_types_pkg::page_t);

    // exception type bits
    localparam int ie_seg_lim = 0;
    localparam int ie_tlb_miss = 1;
    localparam int ie_intr = 3;

endpackage

// File: wb_types_pkg.sv
package wb_types_pkg;

    localparam int word_w = 32;
    localparam int slots = 4;
    localparam int page_w = 20;
    localparam int dest_idx_w = 3;  // register index held in low dest bits

    // result value, two words wide
    typedef logic [2*word_w-1:0] data_t;

    // linear address, destination or EIP
    typedef logic [word_w-1:0] addr_t;

    typedef logic [word_w/2-1:0] sel_t;      // segment selector
    typedef logic [1:0] size_t;              // 0 byte .. 3 quadword
    typedef logic [3:0] ie_type_t;
    typedef logic [page_w-1:0] page_t;
    typedef logic [slots-1:0] slot_mask_t;   // one bit per result slot

    localparam size_t size_quad = 2'd3;

endpackage
